//--- Bender.yml
package:
  name: dmem_subsys

export_include_dirs:
  - .

sources:
  - soc_dmem_pkg.sv
  - dmem_port_decode.sv
  - dmem_mtimer.sv
  - dmem_wb_bridge.sv
  - dmem_resp_stage.sv
  - dmem_subsys_top.sv
  - target: test
    files:
      - tb_wb_slave.sv
      - tb_dmem_subsys.sv

//--- dmem_mtimer.sv
`include "soc_dmem_cfg.svh"

module dmem_mtimer import soc_dmem_pkg::*; (
    input  logic        core_clk_i,
    input  logic        arst_n_i,
    // Memory side
    input  logic        issue_i,
    input  dmem_req_t   req_i,
    output dmem_rsp_t   rsp_o,
    // Timer outputs
    output logic [63:0] timer_val_o,
    output logic        timer_irq_o
);

    // ----------------------------------------------------------
    // Local signals
    // ----------------------------------------------------------
    logic [63:0]            mtime_q;
    logic [63:0]            mtimecmp_q;
    logic                   enable_q;
    mem_resp_e              resp_q;
    logic [31:0]            rdata_q;
    timer_wdata_u           wdata;
    logic [`TIMER_OFS_W-1:0] ofs;
    logic                   acc_ok;     // Word access to a known offset
    logic                   wr_en;
    logic [31:0]            rd_val;

    assign wdata = req_i.wdata;
    assign ofs   = req_i.addr[`TIMER_OFS_W-1:0];

    // Offset decode and read mux
    always_comb begin
        acc_ok = (req_i.width == MEM_WIDTH_WORD);   // Word only
        rd_val = '0;
        case (ofs)
            `TIMER_OFS_CTRL:    rd_val = {31'd0, enable_q};
            `TIMER_OFS_MTIMELO: rd_val = mtime_q[31:0];
            `TIMER_OFS_MTIMEHI: rd_val = mtime_q[63:32];
            `TIMER_OFS_CMPLO:   rd_val = mtimecmp_q[31:0];
            `TIMER_OFS_CMPHI:   rd_val = mtimecmp_q[63:32];
            default:            acc_ok = 1'b0;      // Hole in the map
        endcase
    end

    assign wr_en = issue_i & req_i.cmd & acc_ok;

    // ----------------------------------------------------------
    // Registers and counter
    // ----------------------------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            mtime_q    <= '0;
            mtimecmp_q <= '1;       // No irq until programmed
            enable_q   <= 1'b0;
        end else begin
            // Software write beats the increment
            if (wr_en && (ofs == `TIMER_OFS_MTIMELO)) begin
                mtime_q <= {mtime_q[63:32], wdata.count};
            end else if (wr_en && (ofs == `TIMER_OFS_MTIMEHI)) begin
                mtime_q <= {wdata.count, mtime_q[31:0]};
            end else if (enable_q) begin
                mtime_q <= mtime_q + 64'd1;
            end
            if (wr_en && (ofs == `TIMER_OFS_CMPLO)) begin
                mtimecmp_q[31:0] <= wdata.count;
            end
            if (wr_en && (ofs == `TIMER_OFS_CMPHI)) begin
                mtimecmp_q[63:32] <= wdata.count;
            end
            if (wr_en && (ofs == `TIMER_OFS_CTRL)) begin
                enable_q <= wdata.ctrl.enable;  // Control view of the word
            end
        end
    end

    // Reply, one cycle after issue
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else if (issue_i) begin
            resp_q <= acc_ok ? MEM_RESP_RDY_OK : MEM_RESP_RDY_ER;
        end else begin
            resp_q <= MEM_RESP_IDLE;
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (issue_i) begin
            rdata_q <= rd_val;      // Pre-write value on writes
        end
    end

    assign rsp_o.resp   = resp_q;
    assign rsp_o.rdata  = rdata_q;
    assign timer_val_o  = mtime_q;
    // Level irq while the compare holds
    assign timer_irq_o  = enable_q & (mtime_q >= mtimecmp_q);

    // Single-cycle reply per issue, decoder must not reissue back to back
    a_rsp_after_issue : assert property (
        @(posedge core_clk_i) disable iff (!arst_n_i)
        issue_i |=> (rsp_o.resp != MEM_RESP_IDLE) ##1 (rsp_o.resp == MEM_RESP_IDLE)
    );

endmodule

//--- dmem_port_decode.sv
`include "soc_dmem_cfg.svh"

module dmem_port_decode import soc_dmem_pkg::*; (
    input  logic        core_clk_i,
    input  logic        arst_n_i,
    // Core side
    input  logic        req_i,
    input  dmem_req_t   req_data_i,
    input  logic        done_i,         // From result stage
    output logic        req_ack_o,
    // Unit side
    output dmem_req_t   issue_req_o,    // Held until next accept
    output logic        timer_issue_o,
    output logic        wb_issue_o
);

    // ----------------------------------------------------------
    // Local signals
    // ----------------------------------------------------------
    logic       busy_q;         // Transaction in flight
    logic       pend_q;         // Captured, issue due next edge
    dmem_req_t  req_q;
    logic       timer_hit;
    logic       timer_iss_q;
    logic       wb_iss_q;
    logic       issue_any;

    // Accept only when idle, combinational so the core sees it same cycle
    assign req_ack_o = req_i & ~busy_q;

    // Mask/pattern compare on the held address
    assign timer_hit = (req_q.addr & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN;

    // ----------------------------------------------------------
    // Control
    // ----------------------------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q      <= 1'b0;
            pend_q      <= 1'b0;
            timer_iss_q <= 1'b0;
            wb_iss_q    <= 1'b0;
        end else begin
            if (req_ack_o) begin
                busy_q <= 1'b1;
            end else if (done_i) begin
                busy_q <= 1'b0;     // Reply shown, free next cycle
            end
            pend_q      <= req_ack_o;
            // Exactly one unit gets the pulse
            timer_iss_q <= pend_q & timer_hit;
            wb_iss_q    <= pend_q & ~timer_hit;
        end
    end

    // Request payload, captured at accept
    always_ff @(posedge core_clk_i) begin
        if (req_ack_o) begin
            req_q <= req_data_i;
        end
    end

    assign issue_req_o   = req_q;   // Same bundle to both units
    assign timer_issue_o = timer_iss_q;
    assign wb_issue_o    = wb_iss_q;
    assign issue_any     = timer_iss_q | wb_iss_q;

    // ----------------------------------------------------------
    // Checks
    // ----------------------------------------------------------

    // One issue, then quiet until the result stage reports done
    a_single_outstanding : assert property (
        @(posedge core_clk_i) disable iff (!arst_n_i)
        issue_any |=> (!issue_any throughout done_i[->1])
    );

endmodule

//--- dmem_resp_stage.sv
module dmem_resp_stage import soc_dmem_pkg::*; (
    input  logic        core_clk_i,
    input  logic        arst_n_i,
    input  dmem_rsp_t   timer_rsp_i,
    input  dmem_rsp_t   wb_rsp_i,
    output dmem_rsp_t   rsp_o,          // To core, one cycle
    output logic        done_o          // To decoder, frees busy
);

    mem_resp_e      resp_q;
    logic [31:0]    rdata_q;
    logic           timer_vld;
    logic           wb_vld;

    assign timer_vld = (timer_rsp_i.resp != MEM_RESP_IDLE);
    assign wb_vld    = (wb_rsp_i.resp != MEM_RESP_IDLE);

    // ----------------------------------------------------------
    // Reply merge
    // ----------------------------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            resp_q <= MEM_RESP_IDLE;
        end else begin
            resp_q <= timer_vld ? timer_rsp_i.resp : wb_rsp_i.resp;   // Idle when neither
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (timer_vld) begin
            rdata_q <= timer_rsp_i.rdata;
        end else if (wb_vld) begin
            rdata_q <= wb_rsp_i.rdata;
        end
    end

    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;
    assign done_o      = (resp_q != MEM_RESP_IDLE);    // Same cycle as core reply

    // Only the issued unit may answer
    a_one_reply : assert property (
        @(posedge core_clk_i) disable iff (!arst_n_i)
        !(timer_vld && wb_vld)
    );

endmodule

//--- dmem_subsys_top.sv
module dmem_subsys_top import soc_dmem_pkg::*; (
    input  logic        core_clk_i,
    input  logic        arst_n_i,
    // Core data port
    input  logic        req_i,
    input  dmem_req_t   req_data_i,
    output logic        req_ack_o,
    output dmem_rsp_t   rsp_o,
    // Timer
    output logic [63:0] timer_val_o,
    output logic        timer_irq_o,
    // Wishbone data master
    output logic        wbd_stb_o,
    output logic [31:0] wbd_adr_o,
    output logic        wbd_we_o,
    output logic [31:0] wbd_dat_o,
    output logic [3:0]  wbd_sel_o,
    input  logic [31:0] wbd_dat_i,
    input  logic        wbd_ack_i,
    input  logic        wbd_err_i
);

    // ----------------------------------------------------------
    // Interconnect
    // ----------------------------------------------------------
    dmem_req_t  issue_req;          // Held request to both units
    logic       timer_issue;
    logic       wb_issue;
    dmem_rsp_t  timer_rsp;
    dmem_rsp_t  wb_rsp;
    logic       done;               // Result stage back to decoder

    dmem_port_decode i_port_decode (
        .core_clk_i    (core_clk_i ),
        .arst_n_i      (arst_n_i   ),
        .req_i         (req_i      ),
        .req_data_i    (req_data_i ),
        .done_i        (done       ),
        .req_ack_o     (req_ack_o  ),
        .issue_req_o   (issue_req  ),
        .timer_issue_o (timer_issue),
        .wb_issue_o    (wb_issue   )
    );

    dmem_mtimer i_timer (
        .core_clk_i  (core_clk_i ),
        .arst_n_i    (arst_n_i   ),
        .issue_i     (timer_issue),
        .req_i       (issue_req  ),
        .rsp_o       (timer_rsp  ),
        .timer_val_o (timer_val_o),
        .timer_irq_o (timer_irq_o)
    );

    dmem_wb_bridge i_dmem_wb (
        .core_clk_i (core_clk_i),
        .arst_n_i   (arst_n_i  ),
        .issue_i    (wb_issue  ),
        .req_i      (issue_req ),
        .rsp_o      (wb_rsp    ),
        .wbd_stb_o  (wbd_stb_o ),
        .wbd_adr_o  (wbd_adr_o ),
        .wbd_we_o   (wbd_we_o  ),
        .wbd_dat_o  (wbd_dat_o ),
        .wbd_sel_o  (wbd_sel_o ),
        .wbd_dat_i  (wbd_dat_i ),
        .wbd_ack_i  (wbd_ack_i ),
        .wbd_err_i  (wbd_err_i )
    );

    dmem_resp_stage i_resp_stage (
        .core_clk_i  (core_clk_i),
        .arst_n_i    (arst_n_i  ),
        .timer_rsp_i (timer_rsp ),
        .wb_rsp_i    (wb_rsp    ),
        .rsp_o       (rsp_o     ),
        .done_o      (done      )
    );

endmodule

//--- dmem_wb_bridge.sv
module dmem_wb_bridge import soc_dmem_pkg::*; (
    input  logic        core_clk_i,
    input  logic        arst_n_i,
    // From decoder
    input  logic        issue_i,
    input  dmem_req_t   req_i,      // Held by the decoder for the whole transfer
    output dmem_rsp_t   rsp_o,
    // Wishbone data master
    output logic        wbd_stb_o,
    output logic [31:0] wbd_adr_o,
    output logic        wbd_we_o,
    output logic [31:0] wbd_dat_o,
    output logic [3:0]  wbd_sel_o,
    input  logic [31:0] wbd_dat_i,
    input  logic        wbd_ack_i,
    input  logic        wbd_err_i
);

    logic           stb_q;
    mem_resp_e      resp_q;
    logic [31:0]    rdata_q;
    logic           xfer_end;   // Slave closed the cycle

    assign xfer_end = stb_q & (wbd_ack_i | wbd_err_i);

    // ----------------------------------------------------------
    // Strobe and reply
    // ----------------------------------------------------------
    always_ff @(posedge core_clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            stb_q  <= 1'b0;
            resp_q <= MEM_RESP_IDLE;
        end else begin
            if (issue_i) begin
                stb_q <= 1'b1;          // Edge after issue
            end else if (xfer_end) begin
                stb_q <= 1'b0;
            end
            // ack wins if both show up
            if (stb_q && wbd_ack_i) begin
                resp_q <= MEM_RESP_RDY_OK;
            end else if (stb_q && wbd_err_i) begin
                resp_q <= MEM_RESP_RDY_ER;
            end else begin
                resp_q <= MEM_RESP_IDLE;
            end
        end
    end

    always_ff @(posedge core_clk_i) begin
        if (stb_q && wbd_ack_i) begin
            rdata_q <= wbd_dat_i;
        end
    end

    // Byte lanes from size and low address bits
    always_comb begin
        case (req_i.width)
            MEM_WIDTH_BYTE: wbd_sel_o = 4'b0001 << req_i.addr[1:0];
            MEM_WIDTH_HALF: wbd_sel_o = req_i.addr[1] ? 4'b1100 : 4'b0011;
            default:        wbd_sel_o = 4'b1111;   // Word
        endcase
    end

    assign wbd_stb_o   = stb_q;
    assign wbd_adr_o   = req_i.addr;    // Unchanged, slave ignores [1:0]
    assign wbd_we_o    = req_i.cmd;
    assign wbd_dat_o   = req_i.wdata;
    assign rsp_o.resp  = resp_q;
    assign rsp_o.rdata = rdata_q;

    // Bus held steady while the slave stalls
    a_wb_stable : assert property (
        @(posedge core_clk_i) disable iff (!arst_n_i)
        (wbd_stb_o && !(wbd_ack_i || wbd_err_i)) |=> (wbd_stb_o && $stable(wbd_adr_o))
    );

endmodule

//--- list.f
+incdir+.
soc_dmem_pkg.sv
dmem_port_decode.sv
dmem_mtimer.sv
dmem_wb_bridge.sv
dmem_resp_stage.sv
dmem_subsys_top.sv
tb_wb_slave.sv
tb_dmem_subsys.sv

//--- soc_dmem_cfg.svh
`ifndef SOC_DMEM_CFG_SVH
`define SOC_DMEM_CFG_SVH

// ----------------------------------------------------------
// Data path geometry
// ----------------------------------------------------------

// Core data and address width
`define DMEM_DWIDTH         32

// ----------------------------------------------------------
// Timer placement in the data address map
// ----------------------------------------------------------

// Address hits the timer when (addr & mask) == pattern
`define TIMER_ADDR_MASK     32'hFFFF_FFE0
`define TIMER_ADDR_PATTERN  32'h0049_0000

// Offset field width, the bits cleared in the mask
`define TIMER_OFS_W         5

// ----------------------------------------------------------
// Timer register offsets
// ----------------------------------------------------------

`define TIMER_OFS_CTRL      5'h00   // Enable bit in bit 0
`define TIMER_OFS_MTIMELO   5'h08   // mtime[31:0]
`define TIMER_OFS_MTIMEHI   5'h0C   // mtime[63:32]
`define TIMER_OFS_CMPLO     5'h10   // mtimecmp[31:0]
`define TIMER_OFS_CMPHI     5'h14   // mtimecmp[63:32]

// Offset 04 left unused, gives ready-error

`endif

//--- soc_dmem_pkg.sv
`include "soc_dmem_cfg.svh"

package soc_dmem_pkg;

    // ----------------------------------------------------------
    // Memory interface encodings
    // ----------------------------------------------------------

    // Reply state on the resp lines
    typedef enum logic [1:0] {
        MEM_RESP_IDLE   = 2'b00,    // No reply this cycle
        MEM_RESP_RDY_OK = 2'b01,    // Done, data valid on reads
        MEM_RESP_RDY_ER = 2'b10     // Done with error
    } mem_resp_e;

    // Access size
    typedef enum logic [1:0] {
        MEM_WIDTH_BYTE = 2'b00,
        MEM_WIDTH_HALF = 2'b01,
        MEM_WIDTH_WORD = 2'b10
    } mem_width_e;

    // ----------------------------------------------------------
    // Request and reply bundles
    // ----------------------------------------------------------

    typedef struct packed {
        logic                       cmd;    // 1 = write
        mem_width_e                 width;
        logic [`DMEM_DWIDTH-1:0]    addr;
        logic [`DMEM_DWIDTH-1:0]    wdata;
    } dmem_req_t;                           // 67 bits

    typedef struct packed {
        mem_resp_e                  resp;
        logic [`DMEM_DWIDTH-1:0]    rdata;
    } dmem_rsp_t;                           // 34 bits

    // Timer control register layout
    typedef struct packed {
        logic [30:0]                rsvd;   // Reads back zero
        logic                       enable; // Counter runs when set
    } timer_ctrl_t;

    // One write word, two views of it
    typedef union packed {
        logic [31:0]                count;  // mtime / mtimecmp half
        timer_ctrl_t                ctrl;   // Control register fields
    } timer_wdata_u;

endpackage

//--- tb_dmem_subsys.sv
`include "soc_dmem_cfg.svh"

module tb_dmem_subsys import soc_dmem_pkg::*; ();

    localparam int          TMO = 100;              // Cycles allowed per wait
    localparam logic [31:0] TMR = `TIMER_ADDR_PATTERN;

    logic           clk;
    logic           arst_n;
    logic           req;
    dmem_req_t      req_data;
    logic           req_ack;
    dmem_rsp_t      rsp;
    logic [63:0]    tval;
    logic           irq;
    logic           wb_stb;
    logic [31:0]    wb_adr;
    logic           wb_we;
    logic [31:0]    wb_dat_w;
    logic [3:0]     wb_sel;
    logic [31:0]    wb_dat_r;
    logic           wb_ack;
    logic           wb_err;
    logic [1:0]     wb_dly;

    int             cyc;
    int             err_cnt;
    int             chk_cnt;
    int             test_cnt;
    int             test_err0;
    logic [31:0]    lfsr_q;

    // Reference model state
    logic [31:0]    model_mem [0:255];
    logic [63:0]    m_time;
    logic [63:0]    m_cmp;
    logic           m_en;
    dmem_rsp_t      exp_q [$];      // Expected replies in order
    bit             data_q [$];     // Compare rdata too

    dmem_subsys_top UUT (
        .core_clk_i  (clk     ),
        .arst_n_i    (arst_n  ),
        .req_i       (req     ),
        .req_data_i  (req_data),
        .req_ack_o   (req_ack ),
        .rsp_o       (rsp     ),
        .timer_val_o (tval    ),
        .timer_irq_o (irq     ),
        .wbd_stb_o   (wb_stb  ),
        .wbd_adr_o   (wb_adr  ),
        .wbd_we_o    (wb_we   ),
        .wbd_dat_o   (wb_dat_w),
        .wbd_sel_o   (wb_sel  ),
        .wbd_dat_i   (wb_dat_r),
        .wbd_ack_i   (wb_ack  ),
        .wbd_err_i   (wb_err  )
    );

    tb_wb_slave i_wb_slave (
        .clk_i    (clk     ),
        .arst_n_i (arst_n  ),
        .dly_i    (wb_dly  ),
        .stb_i    (wb_stb  ),
        .adr_i    (wb_adr  ),
        .we_i     (wb_we   ),
        .dat_i    (wb_dat_w),
        .sel_i    (wb_sel  ),
        .dat_o    (wb_dat_r),
        .ack_o    (wb_ack  ),
        .err_o    (wb_err  )
    );

    always #10 clk = ~clk;
    always @(posedge clk) cyc <= cyc + 1;   // Edge counter for latency

    // ----------------------------------------------------------
    // Random bits, reference model and checks
    // ----------------------------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          b;
        v = '0;
        for (b = 0; b < n; b++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
            v      = {v[30:0], lfsr_q[0]};      // One step per bit
        end
        return v;
    endfunction

    function automatic dmem_req_t make_req(input logic wr, input mem_width_e wd,
                                           input logic [31:0] a, input logic [31:0] d);
        dmem_req_t r;
        r.cmd   = wr;
        r.width = wd;
        r.addr  = a;
        r.wdata = d;
        return r;
    endfunction

    // Expected reply, applies writes to the model
    function automatic dmem_rsp_t expect_rsp(input dmem_req_t rq);
        dmem_rsp_t   r;
        logic [4:0]  ofs;
        logic [7:0]  w;
        int          b;
        bit          take;
        r.resp  = MEM_RESP_RDY_OK;
        r.rdata = '0;
        ofs     = rq.addr[4:0];
        w       = rq.addr[9:2];
        if ((rq.addr & `TIMER_ADDR_MASK) == `TIMER_ADDR_PATTERN) begin
            if (rq.width != MEM_WIDTH_WORD || !(ofs inside {`TIMER_OFS_CTRL,
                    `TIMER_OFS_MTIMELO, `TIMER_OFS_MTIMEHI, `TIMER_OFS_CMPLO,
                    `TIMER_OFS_CMPHI})) begin
                r.resp = MEM_RESP_RDY_ER;           // Narrow or unmapped
            end else if (rq.cmd) begin
                case (ofs)
                    `TIMER_OFS_CTRL:    m_en          = rq.wdata[0];
                    `TIMER_OFS_MTIMELO: m_time[31:0]  = rq.wdata;
                    `TIMER_OFS_MTIMEHI: m_time[63:32] = rq.wdata;
                    `TIMER_OFS_CMPLO:   m_cmp[31:0]   = rq.wdata;
                    default:            m_cmp[63:32]  = rq.wdata;
                endcase
            end else begin
                case (ofs)
                    `TIMER_OFS_CTRL:    r.rdata = {31'd0, m_en};
                    `TIMER_OFS_MTIMELO: r.rdata = m_time[31:0];   // Valid while stopped
                    `TIMER_OFS_MTIMEHI: r.rdata = m_time[63:32];
                    `TIMER_OFS_CMPLO:   r.rdata = m_cmp[31:0];
                    default:            r.rdata = m_cmp[63:32];
                endcase
            end
        end else if (rq.addr[31:12] == 20'h0000F) begin
            r.resp = MEM_RESP_RDY_ER;               // Slave error window
        end else if (rq.cmd) begin
            for (b = 0; b < 4; b++) begin
                take = (rq.width == MEM_WIDTH_WORD) ||
                       (rq.width == MEM_WIDTH_HALF && (b / 2) == rq.addr[1]) ||
                       (rq.width == MEM_WIDTH_BYTE && b == rq.addr[1:0]);
                if (take) begin
                    model_mem[w][8*b +: 8] = rq.wdata[8*b +: 8];
                end
            end
        end else begin
            r.rdata = model_mem[w];
        end
        return r;
    endfunction

    task automatic check_rsp(input string name, input dmem_rsp_t got,
                             input dmem_rsp_t exp, input bit with_data);
        chk_cnt++;
        if (got.resp !== exp.resp || (with_data && got.rdata !== exp.rdata)) begin
            err_cnt++;
            $display("** Error @%0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_val(input string name, input logic [63:0] got,
                             input logic [63:0] exp, input bit at_least);
        chk_cnt++;
        if (at_least ? !(got >= exp) : (got !== exp)) begin
            err_cnt++;
            $display("** Error @%0t: %s got %h expected %s%h", $time, name, got,
                     at_least ? ">= " : "", exp);
        end
    endtask

    task automatic fail_on_timeout(input string what);
        $display("Timeout at %0t: %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic test_end(input string name);
        repeat (2) @(posedge clk);      // Let the compare process catch up
        test_cnt++;
        $display("test %0d %s: %s", test_cnt, name,
                 (err_cnt == test_err0) ? "passed" : "failed");
        test_err0 = err_cnt;
    endtask

    // Every reply is compared against the model in order
    always @(negedge clk) begin
        if (arst_n && rsp.resp != MEM_RESP_IDLE) begin
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("Reply at %0t arrived with no request outstanding", $time);
            end else begin
                check_rsp("rsp_o", rsp, exp_q.pop_front(), data_q.pop_front());
            end
        end
    end

    // ----------------------------------------------------------
    // One core access, waits for ack and then for the reply
    // ----------------------------------------------------------
    task automatic access(input dmem_req_t rq, input int lat_exp, output int ack_wait);
        dmem_rsp_t e;
        int        n;
        int        acc_edge;
        e = expect_rsp(rq);
        exp_q.push_back(e);
        data_q.push_back(!rq.cmd && e.resp == MEM_RESP_RDY_OK);
        @(posedge clk);
        #2;
        req      = 1'b1;
        req_data = rq;
        n = 0;
        @(negedge clk);
        while (!req_ack) begin
            n++;
            if (n > TMO) fail_on_timeout("req_ack_o never rose");
            @(negedge clk);
        end
        ack_wait = n;
        acc_edge = cyc + 1;     // Accepted at the coming edge
        @(posedge clk);
        #2;
        req = 1'b0;
        n = 0;
        @(negedge clk);
        while (rsp.resp == MEM_RESP_IDLE) begin
            n++;
            if (n > TMO) fail_on_timeout("no reply on rsp_o");
            @(negedge clk);
        end
        if (lat_exp > 0) check_val("resp latency", cyc - acc_edge, lat_exp, 0);
    endtask

    initial begin
        int          k;
        int          w;
        int          n;
        logic [31:0] d;
        logic [31:0] a;
        mem_width_e  wd;
        dmem_req_t   rq1;
        dmem_req_t   rq2;
        clk      = 1'b0;
        arst_n   = 1'b0;
        req      = 1'b0;
        req_data = '0;
        wb_dly   = 2'd0;
        cyc      = 0;
        err_cnt  = 0;
        chk_cnt  = 0;
        test_cnt = 0;
        test_err0 = 0;
        lfsr_q   = 32'h6335_0933;
        m_time   = '0;
        m_cmp    = '1;
        m_en     = 1'b0;
        repeat (4) @(posedge clk);
        #2;
        arst_n = 1'b1;

        // Reset state
        @(negedge clk);
        check_val("rsp_o.resp", {62'd0, rsp.resp}, 64'd0, 0);
        check_val("wbd_stb_o", wb_stb, 0, 0);
        check_val("timer_irq_o", irq, 0, 0);
        check_val("timer_val_o", tval, 0, 0);
        access(make_req(1'b0, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CTRL, '0), 3, w);
        check_val("req_ack_o wait", w, 0, 0);
        test_end("reset state");

        // Timer registers, stopped counter
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPLO, rand_bits(32)), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPHI, rand_bits(32)), 3, w);
        access(make_req(1'b0, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPLO, '0), 3, w);
        access(make_req(1'b0, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPHI, '0), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_MTIMELO, rand_bits(32)), 3, w);
        access(make_req(1'b0, MEM_WIDTH_WORD, TMR | `TIMER_OFS_MTIMELO, '0), 3, w);
        test_end("timer registers");

        // Wishbone words, then narrow overwrites, then read back
        for (k = 0; k < 6; k++) begin
            wb_dly = rand_bits(2);
            a      = 32'h0000_0200 + 32'(4 * k);
            access(make_req(1'b1, MEM_WIDTH_WORD, a, rand_bits(32)), 0, w);
        end
        for (k = 0; k < 6; k++) begin
            wb_dly = rand_bits(2);
            case (k % 3)
                0:       wd = MEM_WIDTH_HALF;
                1:       wd = MEM_WIDTH_BYTE;
                default: wd = MEM_WIDTH_WORD;
            endcase
            a = 32'h0000_0200 + 32'(4 * k);
            if (wd == MEM_WIDTH_HALF) a[1] = rand_bits(1);
            if (wd == MEM_WIDTH_BYTE) a[1:0] = rand_bits(2);
            access(make_req(1'b1, wd, a, rand_bits(32)), 0, w);
        end
        for (k = 0; k < 6; k++) begin
            wb_dly = rand_bits(2);
            access(make_req(1'b0, MEM_WIDTH_WORD, 32'h0000_0200 + 32'(4 * k), '0), 0, w);
        end
        test_end("wishbone data path");

        // Error replies
        wb_dly = 2'd1;
        access(make_req(1'b0, MEM_WIDTH_WORD, 32'h0000_F010, '0), 0, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, 32'h0000_FFFC, rand_bits(32)), 0, w);
        access(make_req(1'b0, MEM_WIDTH_HALF, TMR | `TIMER_OFS_CTRL, '0), 3, w);
        access(make_req(1'b0, MEM_WIDTH_WORD, TMR | 32'h04, '0), 3, w);   // Hole
        test_end("error replies");

        // Interrupt from a running counter
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_MTIMELO, '0), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_MTIMEHI, '0), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPLO, 32'd40), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CMPHI, '0), 3, w);
        access(make_req(1'b1, MEM_WIDTH_WORD, TMR | `TIMER_OFS_CTRL, 32'd1), 3, w);
        n = 0;
        @(negedge clk);
        while (!irq) begin
            n++;
            if (n > 2 * TMO) fail_on_timeout("timer_irq_o never rose");
            @(negedge clk);
        end
        check_val("timer_val_o", tval, 64'd40, 1);
        test_end("timer interrupt");

        // Second request held behind a slow Wishbone write
        wb_dly = 2'd3;
        d   = rand_bits(32);
        rq1 = make_req(1'b1, MEM_WIDTH_WORD, 32'h0000_0240, d);
        rq2 = make_req(1'b0, MEM_WIDTH_WORD, 32'h0000_0240, '0);
        exp_q.push_back(expect_rsp(rq1));
        data_q.push_back(1'b0);
        exp_q.push_back(expect_rsp(rq2));
        data_q.push_back(1'b1);     // Must read back d
        @(posedge clk);
        #2;
        req      = 1'b1;
        req_data = rq1;
        n = 0;
        @(negedge clk);
        while (!req_ack) begin
            n++;
            if (n > TMO) fail_on_timeout("first request never acknowledged");
            @(negedge clk);
        end
        @(posedge clk);
        #2;
        req_data = rq2;             // req stays high
        n = 0;
        @(negedge clk);
        while (rsp.resp == MEM_RESP_IDLE) begin
            check_val("req_ack_o", req_ack, 0, 0);
            n++;
            if (n > TMO) fail_on_timeout("no reply to the first request");
            @(negedge clk);
        end
        check_val("req_ack_o", req_ack, 0, 0);     // Busy until done clears
        @(negedge clk);
        check_val("req_ack_o", req_ack, 1, 0);
        @(posedge clk);
        #2;
        req = 1'b0;
        n = 0;
        @(negedge clk);
        while (rsp.resp == MEM_RESP_IDLE) begin
            n++;
            if (n > TMO) fail_on_timeout("no reply to the held request");
            @(negedge clk);
        end
        test_end("back-pressure");

        if (exp_q.size() != 0) begin
            err_cnt++;
            $display("%0d expected replies never arrived", exp_q.size());
        end
        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

//--- tb_wb_slave.sv
module tb_wb_slave (
    input  logic        clk_i,
    input  logic        arst_n_i,
    input  logic [1:0]  dly_i,      // Wait states before ack/err
    input  logic        stb_i,
    input  logic [31:0] adr_i,
    input  logic        we_i,
    input  logic [31:0] dat_i,
    input  logic [3:0]  sel_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        err_o
);

    logic [31:0]    mem [0:255];    // Word memory, adr_i[9:2]
    logic [1:0]     cnt_q;
    logic           in_err;
    logic [7:0]     idx;
    int             i;

    assign in_err = (adr_i[31:12] == 20'h0000F);   // 0000_F000 .. 0000_FFFF
    assign idx    = adr_i[9:2];

    // Fill, every word differs with its address
    initial begin
        for (i = 0; i < 256; i++) begin
            mem[i] = 32'h1357_9BDF ^ {4{i[7:0]}};
        end
    end

    // ----------------------------------------------------------
    // Slave cycle, one ack or err pulse per strobe
    // ----------------------------------------------------------
    always @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ack_o <= 1'b0;
            err_o <= 1'b0;
            cnt_q <= 2'd0;
            dat_o <= '0;
        end else if (ack_o || err_o) begin
            ack_o <= 1'b0;      // Master drops stb on this edge
            err_o <= 1'b0;
            cnt_q <= 2'd0;
        end else if (stb_i) begin
            if (cnt_q >= dly_i) begin
                if (in_err) begin
                    err_o <= 1'b1;
                end else begin
                    ack_o <= 1'b1;
                    dat_o <= mem[idx];
                    for (i = 0; i < 4; i++) begin
                        if (we_i && sel_i[i]) begin
                            mem[idx][8*i +: 8] <= dat_i[8*i +: 8];   // Lane write
                        end
                    end
                end
            end else begin
                cnt_q <= cnt_q + 2'd1;      // Still stalling
            end
        end
    end

endmodule
